// ==== pipelinePkg.sv ====
package pipelinePkg;

   // Data and address width of the core.
   localparam int WordSize = 32;

   // Width of a register index, x0 to x31.
   localparam int RegIdxSize = 5;

   // Writeback result source, as decoded upstream.
   typedef enum logic [1:0] {
      srcAlu = 2'b00,
      srcMem = 2'b01,
      srcPc4 = 2'b10
   } resultSrcE;

endpackage

// ==== memRequestIf.sv ====
`timescale 1ns/10ps

interface memRequestIf;

   logic                                reqValid;
   logic                                reqWrite;
   // Word address, byte offset already dropped.
   logic [pipelinePkg::WordSize-3:0]    reqAddr;
   logic [pipelinePkg::WordSize-1:0]    reqWdata;
   logic                                rspValid;
   logic [pipelinePkg::WordSize-1:0]    rspData;

   modport requester (
      output reqValid, reqWrite, reqAddr, reqWdata,
      input  rspValid, rspData
   );

   modport memory (
      input  reqValid, reqWrite, reqAddr, reqWdata,
      output rspValid, rspData
   );

endinterface

// ==== stageBusIf.sv ====
`timescale 1ns/10ps

interface stageBusIf;

   logic                                valid;
   logic [pipelinePkg::WordSize-1:0]    aluResult;
   logic [pipelinePkg::WordSize-1:0]    readData;
   logic [pipelinePkg::WordSize-1:0]    pcPlus4;
   logic [pipelinePkg::RegIdxSize-1:0]  rd;
   logic                                regWrite;
   pipelinePkg::resultSrcE              resultSrc;

   // Sink has no ready, it takes every valid cycle.
   modport source (
      output valid, aluResult, readData, pcPlus4, rd, regWrite, resultSrc
   );

   modport sink (
      input  valid, aluResult, readData, pcPlus4, rd, regWrite, resultSrc
   );

endinterface

// ==== dataMemory.sv ====
`timescale 1ns/10ps

module dataMemory #(
   parameter int MemLatency    = 5,
   parameter int MemDepthWords = 256
) (
   input  logic          clk,
   input  logic          rst,
   memRequestIf.memory   mem
);

   localparam int AddrBits = $clog2(MemDepthWords);

   logic [pipelinePkg::WordSize-1:0] words [MemDepthWords];
   logic [MemDepthWords-1:0]         written;
   logic [AddrBits-1:0]              wordIdx;
   logic [pipelinePkg::WordSize-1:0] readWord;
   logic [pipelinePkg::WordSize-1:0] dataPipe [MemLatency];
   logic [MemLatency-1:0]            validPipe;

   // Address wraps on the array depth.
   assign wordIdx  = mem.reqAddr[AddrBits-1:0];
   assign readWord = written[wordIdx] ? words[wordIdx] : '0;

   // Stores commit at the request edge.
   always_ff @(posedge clk) begin
      if (mem.reqValid && mem.reqWrite) begin
         words[wordIdx] <= mem.reqWdata;
      end
   end

   // Untouched words read back as zero.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         written <= '0;
      end else if (mem.reqValid && mem.reqWrite) begin
         written[wordIdx] <= 1'b1;
      end
   end

   // Read data sampled before this edge's store, zero for stores.
   always_ff @(posedge clk) begin
      dataPipe[0] <= (mem.reqValid && !mem.reqWrite) ? readWord : '0;
      for (int i = 1; i < MemLatency; i++) begin
         dataPipe[i] <= dataPipe[i-1];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         validPipe <= '0;
      end else begin
         validPipe[0] <= mem.reqValid;
         for (int i = 1; i < MemLatency; i++) begin
            validPipe[i] <= validPipe[i-1];
         end
      end
   end

   assign mem.rspValid = validPipe[MemLatency-1];
   assign mem.rspData  = dataPipe[MemLatency-1];

endmodule

// ==== memoryStage.sv ====
`timescale 1ns/10ps

module memoryStage #(
   parameter int MemLatency = 5
) (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               inValid,
   input  logic [pipelinePkg::WordSize-1:0]   aluResult,
   input  logic [pipelinePkg::WordSize-1:0]   writeData,
   input  logic [pipelinePkg::WordSize-1:0]   pcPlus4,
   input  logic [pipelinePkg::RegIdxSize-1:0] rd,
   input  logic                               regWrite,
   input  logic                               memWrite,
   input  pipelinePkg::resultSrcE             resultSrc,
   memRequestIf.requester                     mem,
   stageBusIf.source                          bus,
   output logic [31:0]                        pendingMask
);

   localparam int NumRegs   = 2 ** pipelinePkg::RegIdxSize;
   // Wide enough for every instruction that can be in flight.
   localparam int CountBits = $clog2(MemLatency + 2) + 1;

   logic                               reqValidQ;
   logic                               memWriteQ;
   logic                               regWriteQ;
   logic [pipelinePkg::WordSize-1:0]   aluQ;
   logic [pipelinePkg::WordSize-1:0]   writeDataQ;
   logic [pipelinePkg::WordSize-1:0]   pcPlus4Q;
   logic [pipelinePkg::RegIdxSize-1:0] rdQ;
   pipelinePkg::resultSrcE             srcQ;

   logic [pipelinePkg::WordSize-1:0]   aluPipe [MemLatency];
   logic [pipelinePkg::WordSize-1:0]   pcPlus4Pipe [MemLatency];
   logic [pipelinePkg::RegIdxSize-1:0] rdPipe [MemLatency];
   logic                               regWritePipe [MemLatency];
   pipelinePkg::resultSrcE             srcPipe [MemLatency];

   logic                               retireWrite;
   logic [pipelinePkg::RegIdxSize-1:0] retireRd;
   logic [NumRegs-1:0]                 incMask;
   logic [NumRegs-1:0]                 decMask;
   logic [CountBits-1:0]               pendCount [NumRegs];

   // Request register, the memory sees it one edge after acceptance.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         reqValidQ <= 1'b0;
      end else begin
         reqValidQ <= inValid;
      end
   end

   always_ff @(posedge clk) begin
      if (inValid) begin
         memWriteQ  <= memWrite;
         regWriteQ  <= regWrite;
         aluQ       <= aluResult;
         writeDataQ <= writeData;
         pcPlus4Q   <= pcPlus4;
         rdQ        <= rd;
         srcQ       <= resultSrc;
      end
   end

   assign mem.reqValid = reqValidQ;
   assign mem.reqWrite = memWriteQ;
   assign mem.reqAddr  = aluQ[pipelinePkg::WordSize-1:2];
   assign mem.reqWdata = writeDataQ;

   // Metadata shifts in lockstep with the memory pipeline.
   always_ff @(posedge clk) begin
      aluPipe[0]      <= aluQ;
      pcPlus4Pipe[0]  <= pcPlus4Q;
      rdPipe[0]       <= rdQ;
      regWritePipe[0] <= regWriteQ;
      srcPipe[0]      <= srcQ;
      for (int i = 1; i < MemLatency; i++) begin
         aluPipe[i]      <= aluPipe[i-1];
         pcPlus4Pipe[i]  <= pcPlus4Pipe[i-1];
         rdPipe[i]       <= rdPipe[i-1];
         regWritePipe[i] <= regWritePipe[i-1];
         srcPipe[i]      <= srcPipe[i-1];
      end
   end

   // Pipeline register towards writeback.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bus.valid <= 1'b0;
      end else begin
         bus.valid <= mem.rspValid;
      end
   end

   always_ff @(posedge clk) begin
      if (mem.rspValid) begin
         bus.aluResult <= aluPipe[MemLatency-1];
         bus.readData  <= mem.rspData;
         bus.pcPlus4   <= pcPlus4Pipe[MemLatency-1];
         bus.rd        <= rdPipe[MemLatency-1];
         bus.regWrite  <= regWritePipe[MemLatency-1];
         bus.resultSrc <= srcPipe[MemLatency-1];
      end
   end

   // Pending writes, set on accept and cleared as the bus register loads.
   assign retireWrite = mem.rspValid && regWritePipe[MemLatency-1];
   assign retireRd    = rdPipe[MemLatency-1];

   always_comb begin
      for (int r = 0; r < NumRegs; r++) begin
         incMask[r] = inValid && regWrite && (rd == r) && (r != 0);
         decMask[r] = retireWrite && (retireRd == r) && (r != 0);
      end
   end

   // Counters cover several in-flight writers of one register.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int r = 0; r < NumRegs; r++) begin
            pendCount[r] <= '0;
         end
      end else begin
         for (int r = 0; r < NumRegs; r++) begin
            if (incMask[r] && !decMask[r]) begin
               pendCount[r] <= pendCount[r] + 1'b1;
            end else if (decMask[r] && !incMask[r]) begin
               pendCount[r] <= pendCount[r] - 1'b1;
            end
         end
      end
   end

   always_comb begin
      for (int r = 0; r < NumRegs; r++) begin
         pendingMask[r] = (pendCount[r] != '0);
      end
   end

endmodule

// ==== writebackStage.sv ====
`timescale 1ns/10ps

module writebackStage (
   input  logic                               clk,
   input  logic                               rst,
   stageBusIf.sink                            bus,
   output logic                               wbValid,
   output logic [pipelinePkg::RegIdxSize-1:0] rdW,
   output logic [pipelinePkg::WordSize-1:0]   resultW,
   output logic                               regWriteW,
   output logic                               creditReturn
);

   logic [pipelinePkg::WordSize-1:0] selected;
   logic [pipelinePkg::WordSize-1:0] lastResult;

   always_comb begin
      case (bus.resultSrc)
         pipelinePkg::srcMem: selected = bus.readData;
         pipelinePkg::srcPc4: selected = bus.pcPlus4;
         default:             selected = bus.aluResult;
      endcase
   end

   // Holds the last retired result between retirements.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         lastResult <= '0;
      end else if (bus.valid) begin
         lastResult <= selected;
      end
   end

   assign resultW      = bus.valid ? selected : lastResult;
   assign wbValid      = bus.valid;
   assign rdW          = bus.rd;
   // x0 writes are dropped here.
   assign regWriteW    = bus.valid && bus.regWrite && (bus.rd != '0);
   // One credit back per retirement.
   assign creditReturn = bus.valid;

endmodule

// ==== registerFile.sv ====
`timescale 1ns/10ps

module registerFile (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               writeEnable,
   input  logic [pipelinePkg::RegIdxSize-1:0] writeAddr,
   input  logic [pipelinePkg::WordSize-1:0]   writeData,
   input  logic [pipelinePkg::RegIdxSize-1:0] readAddrA,
   input  logic [pipelinePkg::RegIdxSize-1:0] readAddrB,
   output logic [pipelinePkg::WordSize-1:0]   readDataA,
   output logic [pipelinePkg::WordSize-1:0]   readDataB
);

   localparam int NumRegs = 2 ** pipelinePkg::RegIdxSize;

   logic [pipelinePkg::WordSize-1:0] regs [NumRegs];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int r = 0; r < NumRegs; r++) begin
            regs[r] <= '0;
         end
      end else if (writeEnable && (writeAddr != '0)) begin
         regs[writeAddr] <= writeData;
      end
   end

   // Combinational reads, x0 always zero.
   assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
   assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== pipelineBackEnd.sv ====
`timescale 1ns/10ps

module pipelineBackEnd #(
   parameter int MemLatency    = 5,
   parameter int MemDepthWords = 256,
   // Upstream credit budget, checked outside the RTL.
   parameter int Credits       = 4
) (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               inValid,
   input  logic [pipelinePkg::WordSize-1:0]   aluResult,
   input  logic [pipelinePkg::WordSize-1:0]   writeData,
   input  logic [pipelinePkg::WordSize-1:0]   pcPlus4,
   input  logic [pipelinePkg::RegIdxSize-1:0] rd,
   input  logic                               regWrite,
   input  logic                               memWrite,
   input  pipelinePkg::resultSrcE             resultSrc,
   input  logic [pipelinePkg::RegIdxSize-1:0] readAddrA,
   input  logic [pipelinePkg::RegIdxSize-1:0] readAddrB,
   output logic                               creditReturn,
   output logic [31:0]                        pendingMask,
   output logic                               wbValid,
   output logic [pipelinePkg::RegIdxSize-1:0] rdW,
   output logic [pipelinePkg::WordSize-1:0]   resultW,
   output logic                               regWriteW,
   output logic [pipelinePkg::WordSize-1:0]   readDataA,
   output logic [pipelinePkg::WordSize-1:0]   readDataB
);

   memRequestIf memReq ();
   stageBusIf   stageBus ();

   memoryStage #(
      .MemLatency (MemLatency)
   ) memoryStage_inst (
      .clk         (clk),
      .rst         (rst),
      .inValid     (inValid),
      .aluResult   (aluResult),
      .writeData   (writeData),
      .pcPlus4     (pcPlus4),
      .rd          (rd),
      .regWrite    (regWrite),
      .memWrite    (memWrite),
      .resultSrc   (resultSrc),
      .mem         (memReq.requester),
      .bus         (stageBus.source),
      .pendingMask (pendingMask)
   );

   dataMemory #(
      .MemLatency    (MemLatency),
      .MemDepthWords (MemDepthWords)
   ) dataMemory_inst (
      .clk (clk),
      .rst (rst),
      .mem (memReq.memory)
   );

   writebackStage writebackStage_inst (
      .clk          (clk),
      .rst          (rst),
      .bus          (stageBus.sink),
      .wbValid      (wbValid),
      .rdW          (rdW),
      .resultW      (resultW),
      .regWriteW    (regWriteW),
      .creditReturn (creditReturn)
   );

   registerFile registerFile_inst (
      .clk         (clk),
      .rst         (rst),
      .writeEnable (regWriteW),
      .writeAddr   (rdW),
      .writeData   (resultW),
      .readAddrA   (readAddrA),
      .readAddrB   (readAddrB),
      .readDataA   (readDataA),
      .readDataB   (readDataB)
   );

endmodule

// ==== pipelineBackEnd_properties.sv ====
`timescale 1ns/10ps

module pipelineBackEnd_properties #(
   parameter int MemLatency = 5,
   parameter int Credits    = 4
) (
   input logic                               clk,
   input logic                               rst,
   input logic                               inValid,
   input logic                               creditReturn,
   input logic                               wbValid,
   input logic                               regWriteW,
   input logic [pipelinePkg::RegIdxSize-1:0] rdW
);

   int outstanding;

   // Instructions sent but not yet returned as credits.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         outstanding <= 0;
      end else begin
         outstanding <= outstanding + (inValid ? 1 : 0) - (creditReturn ? 1 : 0);
      end
   end

   creditBound: assert property (@(posedge clk) disable iff (rst)
      outstanding <= Credits)
      else $error("More instructions in flight than credits");

   sendNeedsCredit: assert property (@(posedge clk) disable iff (rst)
      inValid |-> outstanding < Credits)
      else $error("Instruction sent without a credit");

   creditIsRetire: assert property (@(posedge clk) disable iff (rst)
      creditReturn == wbValid)
      else $error("creditReturn differs from wbValid");

   noX0Write: assert property (@(posedge clk) disable iff (rst)
      regWriteW |-> rdW != '0)
      else $error("Register write to x0");

   // No stalls, so every instruction retires at a fixed distance.
   fixedLatency: assert property (@(posedge clk) disable iff (rst)
      inValid |-> ##(MemLatency + 2) wbValid)
      else $error("Instruction did not retire on time");

endmodule

bind pipelineBackEnd pipelineBackEnd_properties #(
   .MemLatency (MemLatency),
   .Credits    (Credits)
) properties_inst (
   .clk          (clk),
   .rst          (rst),
   .inValid      (inValid),
   .creditReturn (creditReturn),
   .wbValid      (wbValid),
   .regWriteW    (regWriteW),
   .rdW          (rdW)
);

// ==== pipelineBackEnd_tb.sv ====
`timescale 1ns/10ps

module pipelineBackEnd_tb;

   localparam int MemLatency = 5;
   localparam int Credits    = 4;
   // Rows from here on go back to back.
   localparam int BurstStart = 12;

   typedef enum logic [1:0] {actStore, actLoad, actAlu, actJump} actionE;

   typedef struct packed {
      actionE      kind;
      logic [31:0] value;
      logic [31:0] data;
      logic [4:0]  rd;
   } rowT;

   typedef struct packed {
      logic [4:0]  rd;
      logic        regWrite;
      logic [31:0] result;
   } retireT;

   logic                   clk;
   logic                   rst;
   logic                   inValid;
   logic [31:0]            aluResult, writeData, pcPlus4;
   logic [4:0]             rd, readAddrA, readAddrB;
   logic                   regWrite, memWrite;
   pipelinePkg::resultSrcE resultSrc;
   logic                   creditReturn, wbValid, regWriteW;
   logic [31:0]            pendingMask, resultW, readDataA, readDataB;
   logic [4:0]             rdW;

   rowT         rows [$];
   retireT      retireQ [$];
   logic [31:0] modelMem [256];
   logic [31:0] modelRegs [32];
   int          pendCnt [32];
   int          credits, creditPend, retired;
   int          cycleCount = 0;
   int          cycleLimit = 1000;
   logic [31:0] rngState;
   // Value resultW keeps between retirements.
   logic [31:0] heldResult;

   pipelineBackEnd #(
      .MemLatency (MemLatency),
      .Credits    (Credits)
   ) pipelineBackEnd_inst (
      .clk (clk), .rst (rst), .inValid (inValid), .aluResult (aluResult),
      .writeData (writeData), .pcPlus4 (pcPlus4), .rd (rd), .regWrite (regWrite),
      .memWrite (memWrite), .resultSrc (resultSrc), .readAddrA (readAddrA),
      .readAddrB (readAddrB), .creditReturn (creditReturn), .pendingMask (pendingMask),
      .wbValid (wbValid), .rdW (rdW), .resultW (resultW), .regWriteW (regWriteW),
      .readDataA (readDataA), .readDataB (readDataB)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic checkEqual(input string name, input logic [31:0] actual,
                             input logic [31:0] want);
      if (actual !== want) begin
         failRun($sformatf("ERR %0t %s actual 0x%08h expected 0x%08h",
                           $time, name, actual, want));
      end
   endtask

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > cycleLimit) begin
         failRun($sformatf("Timeout after %0d cycles with %0d of %0d rows retired",
                           cycleCount, retired, rows.size()));
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] modelMask();
      logic [31:0] mask;
      mask = '0;
      for (int r = 1; r < 32; r++) begin
         mask[r] = (pendCnt[r] != 0);
      end
      return mask;
   endfunction

   task automatic addRow(input actionE kind, input logic [31:0] value,
                         input logic [31:0] data, input logic [4:0] dest);
      rowT row;
      row.kind  = kind;
      row.value = value;
      row.data  = data;
      row.rd    = dest;
      rows.push_back(row);
   endtask

   task automatic loadTable();
      addRow(actAlu,   32'h1234_5678, 32'h0,          5'd1);
      addRow(actStore, 32'h0000_0040, 32'hCAFE_0001, 5'd0);
      addRow(actLoad,  32'h0000_0040, 32'h0,          5'd2);
      addRow(actLoad,  32'h0000_0080, 32'h0,          5'd3);
      addRow(actJump,  32'h0000_2000, 32'h0,          5'd4);
      addRow(actAlu,   32'hDEAD_BEEF, 32'h0,          5'd0);
      addRow(actStore, 32'h0000_0044, 32'h0BAD_F00D, 5'd0);
      addRow(actAlu,   32'h1111_1111, 32'h0,          5'd1);
      addRow(actLoad,  32'h0000_0044, 32'h0,          5'd1);
      addRow(actJump,  32'h0000_3000, 32'h0,          5'd0);
      addRow(actStore, 32'h0000_03FC, 32'h7654_3210, 5'd0);
      addRow(actLoad,  32'h0000_03FC, 32'h0,          5'd5);
      addRow(actAlu,   32'hA0A0_A0A0, 32'h0,          5'd6);
      addRow(actStore, 32'h0000_0048, 32'h1357_9BDF, 5'd0);
      addRow(actLoad,  32'h0000_0048, 32'h0,          5'd7);
      addRow(actAlu,   32'h0000_0005, 32'h0,          5'd7);
      addRow(actJump,  32'h0000_4000, 32'h0,          5'd8);
      addRow(actLoad,  32'h0000_0040, 32'h0,          5'd9);
      addRow(actStore, 32'h0000_0040, 32'h2468_ACE0, 5'd0);
      addRow(actLoad,  32'h0000_0040, 32'h0,          5'd10);
   endtask

   // One falling edge, then every output check for that cycle.
   task automatic tick();
      retireT want;
      @(negedge clk);
      // A credit seen at the last rising edge is usable now.
      credits += creditPend;
      creditPend = creditReturn ? 1 : 0;
      checkEqual("readDataA", readDataA, modelRegs[readAddrA]);
      checkEqual("readDataB", readDataB, modelRegs[readAddrB]);
      if (wbValid) begin
         if (retireQ.size() == 0) begin
            failRun("Retirement seen with no instruction in flight");
         end else begin
            want = retireQ.pop_front();
            checkEqual("rdW", rdW, want.rd);
            checkEqual("regWriteW", regWriteW, want.regWrite);
            checkEqual("resultW", resultW, want.result);
            if (want.regWrite) begin
               modelRegs[want.rd] = want.result;
               pendCnt[want.rd]--;
            end
            heldResult = want.result;
            retired++;
            readAddrA = rdW;
         end
      end else begin
         checkEqual("regWriteW", regWriteW, 1'b0);
         checkEqual("resultW", resultW, heldResult);
      end
      checkEqual("pendingMask", pendingMask, modelMask());
      readAddrB = readAddrB + 1'b1;
   endtask

   task automatic sendRow(input int idx);
      rowT    row;
      retireT want;
      row       = rows[idx];
      aluResult = row.value;
      writeData = row.data;
      pcPlus4   = 32'h0000_1004 + idx * 4;
      rd        = row.rd;
      memWrite  = (row.kind == actStore);
      regWrite  = (row.kind != actStore);
      case (row.kind)
         actLoad: resultSrc = pipelinePkg::srcMem;
         actJump: resultSrc = pipelinePkg::srcPc4;
         default: resultSrc = pipelinePkg::srcAlu;
      endcase
      inValid = 1'b1;
      want.rd       = row.rd;
      want.regWrite = (row.kind != actStore) && (row.rd != 0);
      // Word index into the 256-word memory.
      case (row.kind)
         actLoad: want.result = modelMem[row.value[9:2]];
         actJump: want.result = pcPlus4;
         default: want.result = row.value;
      endcase
      if (row.kind == actStore) begin
         modelMem[row.value[9:2]] = row.data;
      end
      if (want.regWrite) begin
         pendCnt[row.rd]++;
      end
      retireQ.push_back(want);
      credits--;
   endtask

   initial begin
      int gap;
      rst       = 1'b1;
      inValid   = 1'b0;
      aluResult = '0;
      writeData = '0;
      pcPlus4   = '0;
      rd        = '0;
      regWrite  = 1'b0;
      memWrite  = 1'b0;
      resultSrc = pipelinePkg::srcAlu;
      readAddrA = '0;
      readAddrB = '0;
      rngState   = 32'h1609;
      credits    = Credits;
      creditPend = 0;
      retired    = 0;
      heldResult = '0;
      foreach (modelMem[i]) modelMem[i] = '0;
      foreach (modelRegs[i]) modelRegs[i] = '0;
      foreach (pendCnt[i]) pendCnt[i] = 0;
      loadTable();
      cycleLimit = rows.size() * (MemLatency + 5) + 50;
      repeat (3) @(negedge clk);
      rst = 1'b0;
      checkEqual("creditReturn", creditReturn, 1'b0);
      checkEqual("wbValid", wbValid, 1'b0);
      checkEqual("regWriteW", regWriteW, 1'b0);
      checkEqual("pendingMask", pendingMask, '0);
      // Every register reads zero after reset.
      for (int r = 0; r < 32; r++) begin
         readAddrA = r;
         readAddrB = 31 - r;
         tick();
      end
      foreach (rows[i]) begin
         if (i < BurstStart) begin
            rngState = xorshift32(rngState);
            gap = rngState % 4;
         end else begin
            gap = 0;
         end
         repeat (gap) tick();
         while (credits == 0) tick();
         sendRow(i);
         tick();
         inValid = 1'b0;
      end
      while (retired < rows.size()) tick();
      repeat (2) tick();
      checkEqual("credits", credits, Credits);
      checkEqual("retireQ.size", retireQ.size(), 0);
      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== compile.f ====
pipelinePkg.sv
memRequestIf.sv
stageBusIf.sv
dataMemory.sv
memoryStage.sv
writebackStage.sv
registerFile.sv
pipelineBackEnd.sv
pipelineBackEnd_properties.sv
pipelineBackEnd_tb.sv

// ==== Bender.yml ====
package:
  name: pipeline_back_end

sources:
  - pipelinePkg.sv
  - memRequestIf.sv
  - stageBusIf.sv
  - dataMemory.sv
  - memoryStage.sv
  - writebackStage.sv
  - registerFile.sv
  - pipelineBackEnd.sv
  - target: test
    files:
      - pipelineBackEnd_properties.sv
      - pipelineBackEnd_tb.sv
